// ==== verilog/bp_defs.svh ====
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// Instruction address width
`define BP_ADDR_BITS 32

// Global history length in bits
`define BP_GHR_BITS 4

// Pattern history table depth
`define BP_PHT_ENTRIES 16

// Branch target buffer depth
`define BP_BTB_ENTRIES 16

// First fetch address out of reset
`define BP_RESET_VECTOR 32'h0000_1000

// Sequential fetch increment in bytes
`define BP_PC_STEP 4

`endif

// ==== verilog/bp_types_pkg.sv ====
`include "bp_defs.svh"

package bp_types_pkg;

    // Instruction address
    typedef logic [`BP_ADDR_BITS-1:0] addr_t;

    // Global history pattern
    typedef logic [`BP_GHR_BITS-1:0] ghr_t;

    // Counter index into the PHT
    typedef logic [$clog2(`BP_PHT_ENTRIES)-1:0] pht_idx_t;

    // BTB set index, PC bits 5:2
    typedef logic [$clog2(`BP_BTB_ENTRIES)-1:0] btb_idx_t;

    // BTB tag, PC bits 31:6
    // Width is address minus index minus the two byte-offset bits
    typedef logic [`BP_ADDR_BITS-$clog2(`BP_BTB_ENTRIES)-3:0] btb_tag_t;

    // 2-bit saturating counter
    typedef logic [1:0] ctr_t;

endpackage

// ==== verilog/bp_pipe_pkg.sv ====
package bp_pipe_pkg;

    // Prediction made at fetch, carried down the pipeline
    typedef struct packed {
        logic                 pred_taken;
        // Predicted next fetch address
        bp_types_pkg::addr_t  pred_target;
        // History before this fetch's shift-in
        bp_types_pkg::ghr_t   ghr_snap;
    } pred_t;

    // Outcome reported by execute
    typedef struct packed {
        logic                 valid;
        logic                 is_branch;
        logic                 is_jump;
        logic                 taken;
        bp_types_pkg::addr_t  pc;
        bp_types_pkg::addr_t  target;
        // Record returned from fetch
        pred_t                pred;
    } resolve_t;

    // Trap request, level signals
    typedef struct packed {
        logic                 exception;
        logic                 mret;
        bp_types_pkg::addr_t  trap_vector;
        bp_types_pkg::addr_t  epc;
    } trap_t;

endpackage

// ==== verilog/global_history_register.sv ====
`timescale 1ns/1ps

module global_history_register (
    input  logic               clk,
    input  logic               rst,
    input  logic               shift_en,
    input  logic               shift_bit,
    input  logic               repair_en,
    input  bp_types_pkg::ghr_t repair_ghr,
    output bp_types_pkg::ghr_t ghr
);

    always_ff @(posedge clk) begin
        if (rst) begin
            ghr <= '0;
        end else if (repair_en) begin
            // Mispredict repair overrides the speculative shift
            ghr <= repair_ghr;
        end else if (shift_en) begin
            // Newest outcome enters at bit 0
            ghr <= {ghr[$bits(ghr)-2:0], shift_bit};
        end
    end

    // History must stay known, otherwise the PHT index goes X
    a_ghr_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(ghr)
    );

endmodule

// ==== verilog/pattern_history_table.sv ====
`timescale 1ns/1ps
`include "bp_defs.svh"

module pattern_history_table (
    input  logic                   clk,
    input  logic                   rst,
    input  bp_types_pkg::pht_idx_t rd_idx,
    output logic                   rd_taken,
    input  logic                   wr_en,
    input  bp_types_pkg::pht_idx_t wr_idx,
    input  logic                   wr_taken
);

    // Counter array
    bp_types_pkg::ctr_t ctr [`BP_PHT_ENTRIES];

    bp_types_pkg::ctr_t wr_old;

    // Prediction is the counter's upper bit
    assign rd_taken = ctr[rd_idx][1];

    assign wr_old = ctr[wr_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Every counter starts weakly not-taken
            for (int i = 0; i < `BP_PHT_ENTRIES; i++) begin
                ctr[i] <= 2'd1;
            end
        end else if (wr_en) begin
            if (wr_taken) begin
                // Saturate at strongly taken
                if (wr_old != 2'd3) begin
                    ctr[wr_idx] <= wr_old + 2'd1;
                end
            end else begin
                // Saturate at strongly not-taken
                if (wr_old != 2'd0) begin
                    ctr[wr_idx] <= wr_old - 2'd1;
                end
            end
        end
    end

    // Write index comes from the returned record and must be clean
    a_wr_idx_known: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> !$isunknown(wr_idx)
    );

endmodule

// ==== verilog/branch_target_buffer.sv ====
`timescale 1ns/1ps
`include "bp_defs.svh"

module branch_target_buffer (
    input  logic                clk,
    input  logic                rst,
    input  bp_types_pkg::addr_t lookup_pc,
    output logic                hit,
    output bp_types_pkg::addr_t target,
    input  logic                wr_en,
    input  bp_types_pkg::addr_t wr_pc,
    input  bp_types_pkg::addr_t wr_target
);

    localparam int IDX_BITS = $bits(bp_types_pkg::btb_idx_t);

    // Entry storage
    logic                valid_q  [`BP_BTB_ENTRIES];
    bp_types_pkg::btb_tag_t tag_q [`BP_BTB_ENTRIES];
    bp_types_pkg::addr_t target_q [`BP_BTB_ENTRIES];

    bp_types_pkg::btb_idx_t lk_idx;
    bp_types_pkg::btb_tag_t lk_tag;
    bp_types_pkg::btb_idx_t wr_idx;
    bp_types_pkg::btb_tag_t wr_tag;

    // Index sits just above the byte offset, tag takes the rest
    assign lk_idx = lookup_pc[IDX_BITS+1:2];
    assign lk_tag = lookup_pc[`BP_ADDR_BITS-1:IDX_BITS+2];
    assign wr_idx = wr_pc[IDX_BITS+1:2];
    assign wr_tag = wr_pc[`BP_ADDR_BITS-1:IDX_BITS+2];

    // Combinational lookup
    assign hit    = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
    assign target = target_q[lk_idx];

    // Valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BP_BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Tag and target payload
    always_ff @(posedge clk) begin
        if (wr_en) begin
            // Fill or replace, direct mapped
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= wr_target;
        end
    end

endmodule

// ==== verilog/mispredict_check.sv ====
`timescale 1ns/1ps
`include "bp_defs.svh"

module mispredict_check (
    input  bp_pipe_pkg::resolve_t  resolve,
    output logic                   redirect,
    output bp_types_pkg::addr_t    redirect_pc,
    output bp_types_pkg::ghr_t     repair_ghr,
    output logic                   pht_wr,
    output bp_types_pkg::pht_idx_t pht_idx,
    output logic                   btb_wr
);

    localparam int GHR_BITS = $bits(bp_types_pkg::ghr_t);
    localparam int IDX_BITS = $bits(bp_types_pkg::pht_idx_t);

    bp_types_pkg::addr_t actual_next;
    bp_types_pkg::ghr_t  snap;

    assign snap = resolve.pred.ghr_snap;

    // Where fetch should have gone
    always_comb begin
        if (resolve.taken) begin
            actual_next = resolve.target;
        end else begin
            actual_next = resolve.pc + bp_types_pkg::addr_t'(`BP_PC_STEP);
        end
    end

    // Fetch guessed a different next address
    assign redirect    = resolve.valid && (actual_next != resolve.pred.pred_target);
    assign redirect_pc = actual_next;

    // Rebuild history from the fetch-time snapshot
    always_comb begin
        if (resolve.is_branch) begin
            repair_ghr = {snap[GHR_BITS-2:0], resolve.taken};
        end else begin
            // Jumps leave history untouched
            repair_ghr = snap;
        end
    end

    // Counter update only for conditional branches
    assign pht_wr  = resolve.valid && resolve.is_branch;
    // Same gshare hash that fetch used
    assign pht_idx = resolve.pc[IDX_BITS+1:2] ^ snap;

    // Learn targets of anything that actually went taken
    assign btb_wr = resolve.valid &&
                    ((resolve.is_branch && resolve.taken) || resolve.is_jump);

endmodule

// ==== verilog/program_counter.sv ====
`timescale 1ns/1ps
`include "bp_defs.svh"

module program_counter (
    input  logic                clk,
    input  logic                rst,
    input  bp_pipe_pkg::trap_t  trap,
    input  logic                redirect,
    input  bp_types_pkg::addr_t redirect_pc,
    input  logic                btb_hit,
    input  bp_types_pkg::addr_t btb_target,
    input  logic                pht_taken,
    output bp_types_pkg::addr_t fetch_pc,
    output bp_types_pkg::addr_t next_pc,
    output logic                pred_taken
);

    bp_types_pkg::addr_t seq_pc;
    bp_types_pkg::addr_t pc_d;

    assign seq_pc = fetch_pc + bp_types_pkg::addr_t'(`BP_PC_STEP);

    // Taken only when the BTB knows a target
    assign pred_taken = btb_hit && pht_taken;

    // Predicted path, ignores trap and redirect
    assign next_pc = pred_taken ? btb_target : seq_pc;

    // Priority select
    always_comb begin
        if (trap.exception) begin
            // Exception beats mret when both are raised
            pc_d = trap.trap_vector;
        end else if (trap.mret) begin
            pc_d = trap.epc;
        end else if (redirect) begin
            pc_d = redirect_pc;
        end else begin
            pc_d = next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc <= `BP_RESET_VECTOR;
        end else begin
            fetch_pc <= pc_d;
        end
    end

    // Fetch stays on instruction boundaries
    a_fetch_aligned: assert property (
        @(posedge clk) disable iff (rst)
        fetch_pc[1:0] == 2'b00
    );

    // Resolved targets from execute must be aligned too
    a_redirect_aligned: assert property (
        @(posedge clk) disable iff (rst)
        redirect |-> (redirect_pc[1:0] == 2'b00)
    );

endmodule

// ==== verilog/global_prediction_top.sv ====
`timescale 1ns/1ps

module global_prediction_top (
    input  logic                  clk,
    input  logic                  rst,
    input  bp_pipe_pkg::resolve_t resolve,
    input  bp_pipe_pkg::trap_t    trap,
    output bp_types_pkg::addr_t   fetch_pc,
    output bp_pipe_pkg::pred_t    pred,
    output logic                  mispredict
);

    // Fetch side
    logic                   btb_hit;
    bp_types_pkg::addr_t    btb_target;
    logic                   pht_taken;
    bp_types_pkg::pht_idx_t pht_rd_idx;
    bp_types_pkg::addr_t    next_pc;
    logic                   pred_taken;
    bp_types_pkg::ghr_t     ghr;

    // Resolution side
    logic                   redirect;
    bp_types_pkg::addr_t    redirect_pc;
    bp_types_pkg::ghr_t     repair_ghr;
    logic                   pht_wr;
    bp_types_pkg::pht_idx_t pht_wr_idx;
    logic                   btb_wr;

    // gshare hash, PC bits 5:2 with current history
    assign pht_rd_idx = fetch_pc[$bits(pht_rd_idx)+1:2] ^ ghr;

    // Record for the pipeline to carry
    assign pred.pred_taken  = pred_taken;
    assign pred.pred_target = next_pc;
    assign pred.ghr_snap    = ghr;

    assign mispredict = redirect;

    global_history_register u_ghr (
        .clk        (clk),
        .rst        (rst),
        .shift_en   (btb_hit),
        .shift_bit  (pred_taken),
        .repair_en  (redirect),
        .repair_ghr (repair_ghr),
        .ghr        (ghr)
    );

    pattern_history_table u_pht (
        .clk      (clk),
        .rst      (rst),
        .rd_idx   (pht_rd_idx),
        .rd_taken (pht_taken),
        .wr_en    (pht_wr),
        .wr_idx   (pht_wr_idx),
        .wr_taken (resolve.taken)
    );

    branch_target_buffer u_btb (
        .clk       (clk),
        .rst       (rst),
        .lookup_pc (fetch_pc),
        .hit       (btb_hit),
        .target    (btb_target),
        .wr_en     (btb_wr),
        .wr_pc     (resolve.pc),
        .wr_target (resolve.target)
    );

    mispredict_check u_chk (
        .resolve     (resolve),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .repair_ghr  (repair_ghr),
        .pht_wr      (pht_wr),
        .pht_idx     (pht_wr_idx),
        .btb_wr      (btb_wr)
    );

    program_counter u_pc (
        .clk         (clk),
        .rst         (rst),
        .trap        (trap),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .btb_hit     (btb_hit),
        .btb_target  (btb_target),
        .pht_taken   (pht_taken),
        .fetch_pc    (fetch_pc),
        .next_pc     (next_pc),
        .pred_taken  (pred_taken)
    );

endmodule

// ==== testbench/tb_global_prediction.sv ====
`timescale 1ns/1ps
`include "bp_defs.svh"

module tb_global_prediction;

    localparam int CLK_PERIOD = 8;
    // Cycle budgets per test
    localparam int RESET_CYCLES = 4;
    localparam int SEQ_CYCLES   = 24;
    localparam int JUMP_CYCLES  = 40;
    localparam int TRAIN_CYCLES = 140;
    localparam int REPAIR_CYCLES = 6;
    localparam int TRAP_CYCLES  = 12;
    localparam int TOTAL_CYCLES = RESET_CYCLES + SEQ_CYCLES + JUMP_CYCLES + TRAIN_CYCLES +
                                  REPAIR_CYCLES + TRAP_CYCLES;
    // Double the budget as margin
    localparam int WATCHDOG_NS  = TOTAL_CYCLES * CLK_PERIOD * 2;

    logic                  clk;
    logic                  rst;
    bp_pipe_pkg::resolve_t resolve;
    bp_pipe_pkg::trap_t    trap;
    bp_types_pkg::addr_t   fetch_pc;
    bp_pipe_pkg::pred_t    pred;
    logic                  mispredict;

    int errors = 0;
    int checks = 0;
    logic [15:0] lfsr_q = 16'd44;

    // Reference state
    bp_types_pkg::ctr_t     m_ctr   [`BP_PHT_ENTRIES];
    logic                   m_valid [`BP_BTB_ENTRIES];
    bp_types_pkg::btb_tag_t m_tag   [`BP_BTB_ENTRIES];
    bp_types_pkg::addr_t    m_tgt   [`BP_BTB_ENTRIES];
    bp_types_pkg::addr_t    m_pc;
    bp_types_pkg::ghr_t     m_ghr;

    // Branch learned in training, reused by the repair test
    bp_types_pkg::addr_t    branch_pc;
    bp_types_pkg::addr_t    branch_tgt;
    bp_pipe_pkg::pred_t     last_rec;

    global_prediction_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .resolve    (resolve),
        .trap       (trap),
        .fetch_pc   (fetch_pc),
        .pred       (pred),
        .mispredict (mispredict)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // 16-bit Galois LFSR, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic model_hit(input bp_types_pkg::addr_t pc);
        return m_valid[pc[5:2]] && (m_tag[pc[5:2]] == pc[31:6]);
    endfunction

    // gshare guess for the current model fetch PC
    function automatic bp_pipe_pkg::pred_t model_pred();
        bp_pipe_pkg::pred_t     p;
        bp_types_pkg::pht_idx_t ri;
        ri = m_pc[5:2] ^ m_ghr;
        p.pred_taken  = model_hit(m_pc) && m_ctr[ri][1];
        p.pred_target = p.pred_taken ? m_tgt[m_pc[5:2]] : m_pc + 32'd4;
        p.ghr_snap    = m_ghr;
        return p;
    endfunction

    function automatic bp_types_pkg::addr_t resolved_next(input bp_pipe_pkg::resolve_t r);
        return r.taken ? r.target : r.pc + 32'd4;
    endfunction

    function automatic logic model_redirect(input bp_pipe_pkg::resolve_t r);
        return r.valid && (resolved_next(r) != r.pred.pred_target);
    endfunction

    // Mirrors the tables and fetch PC at every rising edge
    always @(posedge clk) begin : model_update
        bp_pipe_pkg::pred_t     p;
        logic                   hit;
        logic                   redir;
        bp_types_pkg::pht_idx_t wi;
        bp_types_pkg::btb_idx_t bi;
        if (rst) begin
            m_pc  = `BP_RESET_VECTOR;
            m_ghr = '0;
            for (int i = 0; i < `BP_PHT_ENTRIES; i++) begin
                m_ctr[i] = 2'd1;
            end
            for (int i = 0; i < `BP_BTB_ENTRIES; i++) begin
                m_valid[i] = 1'b0;
            end
        end else begin
            // Lookups use the state from before this edge
            p     = model_pred();
            hit   = model_hit(m_pc);
            redir = model_redirect(resolve);
            if (resolve.valid && resolve.is_branch) begin
                wi = resolve.pc[5:2] ^ resolve.pred.ghr_snap;
                if (resolve.taken && m_ctr[wi] != 2'd3) begin
                    m_ctr[wi] = m_ctr[wi] + 2'd1;
                end else if (!resolve.taken && m_ctr[wi] != 2'd0) begin
                    m_ctr[wi] = m_ctr[wi] - 2'd1;
                end
            end
            if (resolve.valid && (resolve.is_jump || (resolve.is_branch && resolve.taken))) begin
                bi          = resolve.pc[5:2];
                m_valid[bi] = 1'b1;
                m_tag[bi]   = resolve.pc[31:6];
                m_tgt[bi]   = resolve.target;
            end
            // Repair beats the speculative shift
            if (redir) begin
                m_ghr = resolve.is_branch ?
                        {resolve.pred.ghr_snap[`BP_GHR_BITS-2:0], resolve.taken} :
                        resolve.pred.ghr_snap;
            end else if (hit) begin
                m_ghr = {m_ghr[`BP_GHR_BITS-2:0], p.pred_taken};
            end
            if (trap.exception) begin
                m_pc = trap.trap_vector;
            end else if (trap.mret) begin
                m_pc = trap.epc;
            end else if (redir) begin
                m_pc = resolved_next(resolve);
            end else begin
                m_pc = p.pred_target;
            end
        end
    end

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_outputs(input string name);
        compare(name, 64'(m_pc), 64'(fetch_pc));
        compare(name, 64'(model_pred()), 64'(pred));
        compare(name, 64'(model_redirect(resolve)), 64'(mispredict));
    endtask

    // One clock with new inputs, checked at the falling edge
    task automatic drive_cycle(input string name, input bp_pipe_pkg::resolve_t r,
                               input bp_pipe_pkg::trap_t t);
        @(posedge clk);
        resolve <= r;
        trap    <= t;
        @(negedge clk);
        check_outputs(name);
    endtask

    task automatic idle_cycle(input string name);
        drive_cycle(name, '0, '0);
    endtask

    task automatic wait_for_fetch(input string name, input bp_types_pkg::addr_t addr,
                                  input int limit);
        int n;
        n = 0;
        while (fetch_pc !== addr && n < limit) begin
            idle_cycle(name);
            n++;
        end
        if (fetch_pc !== addr) begin
            errors++;
            $display("%s: fetch did not reach %h within %0d cycles", name, addr, limit);
        end
    endtask

    function automatic bp_pipe_pkg::resolve_t make_resolve(
        input logic is_branch, input logic taken, input bp_types_pkg::addr_t pc,
        input bp_types_pkg::addr_t target, input bp_pipe_pkg::pred_t rec);
        bp_pipe_pkg::resolve_t r;
        r.valid     = 1'b1;
        r.is_branch = is_branch;
        r.is_jump   = !is_branch;
        r.taken     = taken;
        r.pc        = pc;
        r.target    = target;
        r.pred      = rec;
        return r;
    endfunction

    // Test 1
    task automatic reset_sequence();
        bp_types_pkg::addr_t expected_pc;
        expected_pc = `BP_RESET_VECTOR;
        compare("reset_seq", 64'(expected_pc), 64'(fetch_pc));
        compare("reset_seq", 64'(0), 64'(mispredict));
        for (int i = 0; i < 20; i++) begin
            idle_cycle("reset_seq");
            expected_pc = expected_pc + bp_types_pkg::addr_t'(`BP_PC_STEP);
            compare("reset_seq", 64'(expected_pc), 64'(fetch_pc));
            compare("reset_seq", 64'(0), 64'(pred.pred_taken));
        end
    endtask

    // Test 2
    task automatic jump_then_hit();
        bp_pipe_pkg::pred_t  rec;
        bp_types_pkg::addr_t jump_pc;
        bp_types_pkg::addr_t jump_tgt;
        jump_pc  = 32'h0000_1080;
        jump_tgt = 32'h0000_1040;
        // No prediction was made for this jump
        rec.pred_taken  = 1'b0;
        rec.pred_target = jump_pc + 32'd4;
        rec.ghr_snap    = pred.ghr_snap;
        drive_cycle("jump_learn", make_resolve(1'b0, 1'b1, jump_pc, jump_tgt, rec), '0);
        compare("jump_learn", 64'(1), 64'(mispredict));
        idle_cycle("jump_learn");
        compare("jump_learn", 64'(jump_tgt), 64'(fetch_pc));
        // Backward jump, so sequential fetch comes round again
        wait_for_fetch("jump_learn", jump_pc, 32);
        compare("jump_learn", 64'(1), 64'(dut0.btb_hit));
        idle_cycle("jump_learn");
    endtask

    // Test 3
    task automatic branch_training();
        logic [31:0]        bits;
        bp_pipe_pkg::pred_t rec;
        bits       = take_bits(8);
        branch_pc  = 32'h0000_2000 + {22'd0, bits[7:0], 2'b00};
        bits       = take_bits(8);
        branch_tgt = 32'h0000_3000 + {22'd0, bits[7:0], 2'b00};
        // Keep branch and loop-back jump in separate BTB sets
        if (branch_tgt[5:2] == branch_pc[5:2]) begin
            branch_tgt = branch_tgt ^ 32'h4;
        end
        // Resolve the current fetch as a jump into the branch
        drive_cycle("branch_train", make_resolve(1'b0, 1'b1, fetch_pc, branch_pc, pred), '0);
        wait_for_fetch("branch_train", branch_pc, 4);
        for (int i = 0; i < 10; i++) begin
            rec = pred;
            drive_cycle("branch_train",
                        make_resolve(1'b1, 1'b1, branch_pc, branch_tgt, rec), '0);
            wait_for_fetch("branch_train", branch_tgt, 4);
            rec = pred;
            // Jump at the target closes the loop
            drive_cycle("branch_train",
                        make_resolve(1'b0, 1'b1, branch_tgt, branch_pc, rec), '0);
            wait_for_fetch("branch_train", branch_pc, 4);
        end
        // History settles, counter saturates
        last_rec = pred;
        compare("branch_train", 64'(1), 64'(pred.pred_taken));
        compare("branch_train", 64'(branch_tgt), 64'(pred.pred_target));
    endtask

    // Test 4
    task automatic not_taken_repair();
        bp_types_pkg::ghr_t expected_ghr;
        expected_ghr = {last_rec.ghr_snap[`BP_GHR_BITS-2:0], 1'b0};
        drive_cycle("ghr_repair",
                    make_resolve(1'b1, 1'b0, branch_pc, branch_tgt, last_rec), '0);
        compare("ghr_repair", 64'(1), 64'(mispredict));
        idle_cycle("ghr_repair");
        compare("ghr_repair", 64'(branch_pc + 32'd4), 64'(fetch_pc));
        compare("ghr_repair", 64'(expected_ghr), 64'(pred.ghr_snap));
    endtask

    // Test 5
    task automatic trap_priority();
        bp_pipe_pkg::trap_t    t;
        bp_pipe_pkg::resolve_t r;
        logic [31:0]           bits;
        bits          = take_bits(10);
        t             = '0;
        t.trap_vector = 32'h0000_0100;
        t.epc         = 32'h0000_4000 + {20'd0, bits[9:0], 2'b00};
        t.exception   = 1'b1;
        drive_cycle("trap_prio", '0, t);
        idle_cycle("trap_prio");
        compare("trap_prio", 64'(t.trap_vector), 64'(fetch_pc));
        t.exception = 1'b0;
        t.mret      = 1'b1;
        drive_cycle("trap_prio", '0, t);
        idle_cycle("trap_prio");
        compare("trap_prio", 64'(t.epc), 64'(fetch_pc));
        // Both raised
        t.exception = 1'b1;
        drive_cycle("trap_prio", '0, t);
        idle_cycle("trap_prio");
        compare("trap_prio", 64'(t.trap_vector), 64'(fetch_pc));
        // Both raised while a jump mispredicts
        r = make_resolve(1'b0, 1'b1, fetch_pc, 32'h0000_5000, pred);
        r.pred.pred_target = '0;
        drive_cycle("trap_prio", r, t);
        compare("trap_prio", 64'(1), 64'(mispredict));
        idle_cycle("trap_prio");
        compare("trap_prio", 64'(t.trap_vector), 64'(fetch_pc));
    endtask

    initial begin
        rst     = 1'b1;
        resolve = '0;
        trap    = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        reset_sequence();
        jump_then_hit();
        branch_training();
        not_taken_repair();
        trap_priority();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+verilog
verilog/bp_types_pkg.sv
verilog/bp_pipe_pkg.sv
verilog/global_history_register.sv
verilog/pattern_history_table.sv
verilog/branch_target_buffer.sv
verilog/mispredict_check.sv
verilog/program_counter.sv
verilog/global_prediction_top.sv
testbench/tb_global_prediction.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the predictor testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_global_prediction -f filelist.f -o sim_tb > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/sim_tb > "$SIM_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status, see $SIM_LOG"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$SIM_LOG"; then
    echo "Simulation reported failure, see $SIM_LOG"
    exit 1
fi

echo "Simulation finished without failure, see $SIM_LOG"
exit 0
